// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
TOP       ?= tb_uart_host
FILELIST  ?= files.f

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: common/uart_ctrl_pkg.sv
`default_nettype none

package uart_ctrl_pkg;

  //////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////

  typedef logic [7:0] byte_t;
  typedef logic [3:0] addr_t;

  // Counts banner bytes 0..15, then payload bytes 16..31
  typedef logic [4:0] idx_t;

  typedef enum logic [2:0] {
    MODE_IDLE,
    MODE_ENTER_IP,
    MODE_ENTER_KEY,
    MODE_RUN,
    MODE_VIEW_IP,
    MODE_VIEW_KEY
  } mode_t;

  //////////////////////////////////////////////////
  // Sizes and codes
  //////////////////////////////////////////////////

  localparam int BANNER_LEN = 16;
  localparam int MEM_DEPTH  = 16;

  // Host sends each code twice in a row
  localparam byte_t CMD_ENTER_IP  = 8'h11;
  localparam byte_t CMD_ENTER_KEY = 8'h22;
  localparam byte_t CMD_RUN       = 8'h33;
  localparam byte_t CMD_VIEW_IP   = 8'h44;
  localparam byte_t CMD_VIEW_KEY  = 8'h55;

  localparam byte_t PAD_CHAR = 8'h20;

endpackage

`default_nettype wire

// File: control/cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fsm (
  input  wire                   CLK,
  input  wire                   CPU_RESETN,
  input  wire uart_ctrl_pkg::byte_t uart_rx_data,
  input  wire                   uart_rx_vld,
  input  wire                   ap_done,
  input  wire                   seq_done,
  output uart_ctrl_pkg::mode_t  mode,
  output logic                  mode_enter,
  output logic                  ap_start,
  output logic                  accel_own
);

  import uart_ctrl_pkg::*;

  byte_t last_byte;
  mode_t cmd_mode;
  mode_t next_mode;
  logic  cmd_hit;
  logic  mode_chg;

  // Decode of the incoming byte as a command
  always_comb begin
    cmd_hit  = 1'b1;
    cmd_mode = MODE_IDLE;
    case (uart_rx_data)
      CMD_ENTER_IP:  cmd_mode = MODE_ENTER_IP;
      CMD_ENTER_KEY: cmd_mode = MODE_ENTER_KEY;
      CMD_RUN:       cmd_mode = MODE_RUN;
      CMD_VIEW_IP:   cmd_mode = MODE_VIEW_IP;
      CMD_VIEW_KEY:  cmd_mode = MODE_VIEW_KEY;
      default:       cmd_hit  = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Mode transitions
  //////////////////////////////////////////////////

  always_comb begin
    next_mode = mode;
    case (mode)
      MODE_IDLE: begin
        if (uart_rx_vld && (uart_rx_data == last_byte) && cmd_hit) begin
          next_mode = cmd_mode;
        end
      end
      MODE_RUN: begin
        if (ap_done) begin
          next_mode = MODE_IDLE;
        end
      end
      // Enter and view modes end when the transfer completes
      default: begin
        if (seq_done) begin
          next_mode = MODE_IDLE;
        end
      end
    endcase
  end

  assign mode_chg = (next_mode != mode);

  always_ff @(posedge CLK or posedge CPU_RESETN) begin
    if (CPU_RESETN) begin
      mode       <= MODE_IDLE;
      mode_enter <= 1'b0;
      ap_start   <= 1'b0;
      last_byte  <= '0;
    end else begin
      mode       <= next_mode;
      mode_enter <= mode_chg;
      ap_start   <= mode_chg && (next_mode == MODE_RUN);
      // History restarts with each new mode
      if (mode_chg) begin
        last_byte <= '0;
      end else if (uart_rx_vld) begin
        last_byte <= uart_rx_data;
      end
    end
  end

  assign accel_own = (mode == MODE_RUN);

endmodule

`default_nettype wire

// File: files.f
+incdir+sim
common/uart_ctrl_pkg.sv
control/cmd_fsm.sv
logic/banner_rom.sv
logic/xfer_seq.sv
logic/mem_bank.sv
logic/uart_host_top.sv
sim/tb_uart_host.sv

// File: logic/banner_rom.sv
`timescale 1ns/1ps
`default_nettype none

module banner_rom (
  input  wire uart_ctrl_pkg::mode_t mode,
  input  wire uart_ctrl_pkg::idx_t  banner_idx,
  output uart_ctrl_pkg::byte_t      banner_byte
);

  import uart_ctrl_pkg::*;

  // Character 0 sits in the top byte
  logic [8*BANNER_LEN-1:0] text;

  always_comb begin
    case (mode)
      MODE_ENTER_IP:  text = "Enter Input     ";
      MODE_ENTER_KEY: text = "Enter Key       ";
      MODE_RUN:       text = "Run             ";
      MODE_VIEW_IP:   text = "View Input      ";
      MODE_VIEW_KEY:  text = "View Key        ";
      default:        text = "Idle            ";
    endcase
  end

  // Indices past the text read as padding
  always_comb begin
    if (banner_idx < idx_t'(BANNER_LEN)) begin
      banner_byte = text[(BANNER_LEN - 1 - int'(banner_idx[3:0])) * 8 +: 8];
    end else begin
      banner_byte = PAD_CHAR;
    end
  end

endmodule

`default_nettype wire

// File: logic/mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bank (
  input  wire                       CLK,
  input  wire                       accel_own,
  input  wire uart_ctrl_pkg::addr_t host_addr,
  input  wire                       host_we,
  input  wire uart_ctrl_pkg::byte_t host_wdata,
  input  wire                       accel_ce,
  input  wire                       accel_we,
  input  wire uart_ctrl_pkg::addr_t accel_addr,
  input  wire uart_ctrl_pkg::byte_t accel_wdata,
  output uart_ctrl_pkg::byte_t      rdata
);

  import uart_ctrl_pkg::*;

  byte_t mem [MEM_DEPTH];

  logic  ce;
  logic  we;
  addr_t addr;
  byte_t wdata;

  // Host side reads every cycle
  assign ce    = accel_own ? accel_ce    : 1'b1;
  assign we    = accel_own ? accel_we    : host_we;
  assign addr  = accel_own ? accel_addr  : host_addr;
  assign wdata = accel_own ? accel_wdata : host_wdata;

  always_ff @(posedge CLK) begin
    if (ce) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// File: logic/uart_host_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_host_top (
  input  wire                       CLK,
  input  wire                       CPU_RESETN,
  input  wire uart_ctrl_pkg::byte_t uart_rx_data,
  input  wire                       uart_rx_vld,
  input  wire                       uart_busy,
  output uart_ctrl_pkg::byte_t      uart_tx_data,
  output logic                      uart_tx_vld,
  output logic                      ap_start,
  input  wire                       ap_done,
  input  wire                       ip_mem_ce,
  input  wire                       ip_mem_we,
  input  wire uart_ctrl_pkg::addr_t ip_mem_addr,
  input  wire uart_ctrl_pkg::byte_t ip_mem_wdata,
  output uart_ctrl_pkg::byte_t      ip_mem_rdata,
  input  wire                       key_mem_ce,
  input  wire                       key_mem_we,
  input  wire uart_ctrl_pkg::addr_t key_mem_addr,
  input  wire uart_ctrl_pkg::byte_t key_mem_wdata,
  output uart_ctrl_pkg::byte_t      key_mem_rdata
);

  import uart_ctrl_pkg::*;

  mode_t mode;
  logic  mode_enter;
  logic  accel_own;
  logic  seq_done;
  idx_t  banner_idx;
  byte_t banner_byte;
  addr_t host_addr;
  byte_t host_wdata;
  logic  ip_host_we;
  logic  key_host_we;

  //////////////////////////////////////////////////
  // Control path
  //////////////////////////////////////////////////

  cmd_fsm cmd_fsm_i (
    .CLK          (CLK),
    .CPU_RESETN   (CPU_RESETN),
    .uart_rx_data (uart_rx_data),
    .uart_rx_vld  (uart_rx_vld),
    .ap_done      (ap_done),
    .seq_done     (seq_done),
    .mode         (mode),
    .mode_enter   (mode_enter),
    .ap_start     (ap_start),
    .accel_own    (accel_own)
  );

  xfer_seq xfer_seq_i (
    .CLK          (CLK),
    .CPU_RESETN   (CPU_RESETN),
    .mode         (mode),
    .mode_enter   (mode_enter),
    .uart_rx_data (uart_rx_data),
    .uart_rx_vld  (uart_rx_vld),
    .uart_busy    (uart_busy),
    .banner_byte  (banner_byte),
    .ip_rdata     (ip_mem_rdata),
    .key_rdata    (key_mem_rdata),
    .banner_idx   (banner_idx),
    .uart_tx_data (uart_tx_data),
    .uart_tx_vld  (uart_tx_vld),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .ip_host_we   (ip_host_we),
    .key_host_we  (key_host_we),
    .seq_done     (seq_done)
  );

  banner_rom banner_rom_i (
    .mode        (mode),
    .banner_idx  (banner_idx),
    .banner_byte (banner_byte)
  );

  //////////////////////////////////////////////////
  // Shared memories
  //////////////////////////////////////////////////

  mem_bank ip_bank (
    .CLK         (CLK),
    .accel_own   (accel_own),
    .host_addr   (host_addr),
    .host_we     (ip_host_we),
    .host_wdata  (host_wdata),
    .accel_ce    (ip_mem_ce),
    .accel_we    (ip_mem_we),
    .accel_addr  (ip_mem_addr),
    .accel_wdata (ip_mem_wdata),
    .rdata       (ip_mem_rdata)
  );

  mem_bank key_bank (
    .CLK         (CLK),
    .accel_own   (accel_own),
    .host_addr   (host_addr),
    .host_we     (key_host_we),
    .host_wdata  (host_wdata),
    .accel_ce    (key_mem_ce),
    .accel_we    (key_mem_we),
    .accel_addr  (key_mem_addr),
    .accel_wdata (key_mem_wdata),
    .rdata       (key_mem_rdata)
  );

endmodule

`default_nettype wire

// File: logic/xfer_seq.sv
`timescale 1ns/1ps
`default_nettype none

module xfer_seq (
  input  wire                       CLK,
  input  wire                       CPU_RESETN,
  input  wire uart_ctrl_pkg::mode_t mode,
  input  wire                       mode_enter,
  input  wire uart_ctrl_pkg::byte_t uart_rx_data,
  input  wire                       uart_rx_vld,
  input  wire                       uart_busy,
  input  wire uart_ctrl_pkg::byte_t banner_byte,
  input  wire uart_ctrl_pkg::byte_t ip_rdata,
  input  wire uart_ctrl_pkg::byte_t key_rdata,
  output uart_ctrl_pkg::idx_t       banner_idx,
  output uart_ctrl_pkg::byte_t      uart_tx_data,
  output logic                      uart_tx_vld,
  output uart_ctrl_pkg::addr_t      host_addr,
  output uart_ctrl_pkg::byte_t      host_wdata,
  output logic                      ip_host_we,
  output logic                      key_host_we,
  output logic                      seq_done
);

  import uart_ctrl_pkg::*;

  idx_t  cnt;
  logic  fin;
  logic  busy_d;
  logic  busy_fall;
  logic  banner_phase;
  logic  last;
  logic  enter_mode;
  logic  view_mode;
  logic  host_we;
  logic  tx_vld_q;
  logic  tx_mem_q;
  byte_t tx_byte_q;
  byte_t view_rdata;

  assign busy_fall    = busy_d && !uart_busy;
  assign banner_phase = (cnt < idx_t'(BANNER_LEN));
  assign last         = (cnt == idx_t'(BANNER_LEN + MEM_DEPTH - 1));
  assign enter_mode   = (mode == MODE_ENTER_IP) || (mode == MODE_ENTER_KEY);
  assign view_mode    = (mode == MODE_VIEW_IP) || (mode == MODE_VIEW_KEY);

  // Count is stale in the entry cycle
  assign banner_idx = mode_enter ? '0 : cnt;
  assign host_addr  = cnt[3:0];
  assign host_wdata = uart_rx_data;

  assign host_we     = enter_mode && uart_rx_vld && !banner_phase && !fin && !mode_enter;
  assign ip_host_we  = host_we && (mode == MODE_ENTER_IP);
  assign key_host_we = host_we && (mode == MODE_ENTER_KEY);

  //////////////////////////////////////////////////
  // Byte counter and transmit pacing
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge CPU_RESETN) begin
    if (CPU_RESETN) begin
      busy_d   <= 1'b0;
      cnt      <= '0;
      fin      <= 1'b0;
      tx_vld_q <= 1'b0;
      tx_mem_q <= 1'b0;
      seq_done <= 1'b0;
    end else begin
      busy_d   <= uart_busy;
      tx_vld_q <= 1'b0;
      seq_done <= 1'b0;
      if (mode_enter) begin
        cnt      <= idx_t'(1);
        fin      <= 1'b0;
        tx_vld_q <= 1'b1;
        tx_mem_q <= 1'b0;
      end else if (host_we) begin
        if (last) begin
          fin      <= 1'b1;
          seq_done <= 1'b1;
        end else begin
          cnt <= cnt + idx_t'(1);
        end
      end else if (busy_fall) begin
        if (banner_phase) begin
          cnt      <= cnt + idx_t'(1);
          tx_vld_q <= 1'b1;
          tx_mem_q <= 1'b0;
        end else if (view_mode && fin) begin
          seq_done <= 1'b1;
        end else if (view_mode) begin
          // Address goes out now, memory byte next cycle
          tx_vld_q <= 1'b1;
          tx_mem_q <= 1'b1;
          if (last) begin
            fin <= 1'b1;
          end else begin
            cnt <= cnt + idx_t'(1);
          end
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (mode_enter || (busy_fall && banner_phase)) begin
      tx_byte_q <= banner_byte;
    end
  end

  assign view_rdata   = (mode == MODE_VIEW_KEY) ? key_rdata : ip_rdata;
  assign uart_tx_data = tx_mem_q ? view_rdata : tx_byte_q;
  assign uart_tx_vld  = tx_vld_q;

endmodule

`default_nettype wire

// File: sim/host_tasks.svh
`ifndef HOST_TASKS_SVH
`define HOST_TASKS_SVH

  //////////////////////////////////////////////////
  // Random data and compare tasks
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic byte_t rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got 0x%02h, expected 0x%02h",
                          $time, what, got, exp));
    end
  endtask

  task automatic compare_mode_pulse(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                          $time, what, got, exp));
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                          $time, what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Host side helpers
  //////////////////////////////////////////////////

  task automatic send_rx_byte(input byte_t b);
    @(posedge CLK);
    #1;
    uart_rx_data = b;
    uart_rx_vld  = 1'b1;
    @(posedge CLK);
    #1;
    uart_rx_vld = 1'b0;
  endtask

  task automatic wait_line_idle();
    int cycles;
    cycles = 0;
    while (line_active || uart_busy) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 20) begin
        abort_run("The UART line stayed busy for more than 20 cycles");
      end
    end
  endtask

  // A command is the same code twice
  task automatic send_command(input byte_t code);
    wait_line_idle();
    send_rx_byte(code);
    send_rx_byte(code);
  endtask

  task automatic wait_tx_count(input int n);
    int cycles;
    cycles = 0;
    while (tx_q.size() < n) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 200 * n) begin
        abort_run($sformatf("Timed out at %0t waiting for %0d transmitted bytes, got %0d",
                            $time, n, tx_q.size()));
      end
    end
  endtask

  // Text is padded with spaces to the full banner
  task automatic expect_banner(input string text);
    byte_t exp;
    wait_tx_count(BANNER_LEN);
    for (int i = 0; i < BANNER_LEN; i++) begin
      exp = (i < text.len()) ? byte_t'(text[i]) : 8'h20;
      compare_byte(tx_q.pop_front(), exp, $sformatf("banner %s char %0d", text, i));
    end
  endtask

  task automatic expect_payload(input byte_t exp [MEM_DEPTH], input string what);
    wait_tx_count(MEM_DEPTH);
    for (int i = 0; i < MEM_DEPTH; i++) begin
      compare_byte(tx_q.pop_front(), exp[i], $sformatf("%s %0d", what, i));
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_stays_quiet();
    for (int c = 0; c < 3; c++) begin
      @(posedge CLK);
      #1;
      compare_mode_pulse(uart_tx_vld, 1'b0, "uart_tx_vld in reset");
      compare_mode_pulse(ap_start, 1'b0, "ap_start in reset");
    end
    CPU_RESETN = 1'b0;
    for (int c = 0; c < 50; c++) begin
      @(posedge CLK);
      #1;
      compare_mode_pulse(uart_tx_vld, 1'b0, "uart_tx_vld after reset");
      compare_mode_pulse(ap_start, 1'b0, "ap_start after reset");
    end
    compare_count(tx_q.size(), 0, "bytes sent after reset");
  endtask

  task automatic enter_input_bytes();
    send_command(CMD_ENTER_IP);
    expect_banner("Enter Input");
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ip_model[i] = rand_byte();
      send_rx_byte(ip_model[i]);
    end
    expect_banner("Idle");
  endtask

  task automatic enter_and_view_key();
    send_command(CMD_ENTER_KEY);
    expect_banner("Enter Key");
    for (int i = 0; i < MEM_DEPTH; i++) begin
      key_model[i] = rand_byte();
      send_rx_byte(key_model[i]);
    end
    expect_banner("Idle");
    send_command(CMD_VIEW_KEY);
    expect_banner("View Key");
    expect_payload(key_model, "key byte");
    expect_banner("Idle");
  endtask

  task automatic run_and_view_result();
    int starts;
    int dones;
    starts = ap_start_cnt;
    dones  = ap_done_cnt;
    send_command(CMD_RUN);
    expect_banner("Run");
    wait_tx_count(1);
    compare_count(ap_done_cnt - dones, 1, "ap_done pulses before the Idle banner");
    expect_banner("Idle");
    compare_count(ap_start_cnt - starts, 1, "ap_start cycles for one run");
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ip_model[i] = ip_model[i] ^ key_model[i];
    end
    send_command(CMD_VIEW_IP);
    expect_banner("View Input");
    expect_payload(ip_model, "result byte");
    expect_banner("Idle");
  endtask

  task automatic reject_non_commands();
    int starts;
    starts = ap_start_cnt;
    wait_line_idle();
    send_rx_byte(8'h11);
    send_rx_byte(8'h22);
    send_rx_byte(8'h66);
    send_rx_byte(8'h66);
    repeat (200) @(posedge CLK);
    compare_count(tx_q.size(), 0, "bytes sent after non-commands");
    compare_count(ap_start_cnt - starts, 0, "ap_start cycles after non-commands");
    send_command(CMD_VIEW_KEY);
    expect_banner("View Key");
    expect_payload(key_model, "key byte");
    expect_banner("Idle");
  endtask

`endif

// File: sim/tb_uart_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_host;

  import uart_ctrl_pkg::*;

  localparam int CLK_HALF_NS = 4;
  localparam int BUSY_CYCLES = 5;
  // Modelled compute latency outlasts one banner
  localparam int ACCEL_LAT   = 100;
  localparam int WATCHDOG_NS = 5 * 40 * 8 * 8 * 4;

  logic  CLK;
  logic  CPU_RESETN;
  byte_t uart_rx_data;
  logic  uart_rx_vld;
  logic  uart_busy;
  byte_t uart_tx_data;
  logic  uart_tx_vld;
  logic  ap_start;
  logic  ap_done;
  logic  ip_mem_ce;
  logic  ip_mem_we;
  addr_t ip_mem_addr;
  byte_t ip_mem_wdata;
  byte_t ip_mem_rdata;
  logic  key_mem_ce;
  logic  key_mem_we;
  addr_t key_mem_addr;
  byte_t key_mem_wdata;
  byte_t key_mem_rdata;

  byte_t       tx_q [$];
  logic        line_active  = 1'b0;
  int          ap_start_cnt = 0;
  int          ap_done_cnt  = 0;
  logic [31:0] rng_state    = 32'd68;
  byte_t       ip_model  [MEM_DEPTH];
  byte_t       key_model [MEM_DEPTH];

  uart_host_top uart_host_top_i (
    .CLK           (CLK),
    .CPU_RESETN    (CPU_RESETN),
    .uart_rx_data  (uart_rx_data),
    .uart_rx_vld   (uart_rx_vld),
    .uart_busy     (uart_busy),
    .uart_tx_data  (uart_tx_data),
    .uart_tx_vld   (uart_tx_vld),
    .ap_start      (ap_start),
    .ap_done       (ap_done),
    .ip_mem_ce     (ip_mem_ce),
    .ip_mem_we     (ip_mem_we),
    .ip_mem_addr   (ip_mem_addr),
    .ip_mem_wdata  (ip_mem_wdata),
    .ip_mem_rdata  (ip_mem_rdata),
    .key_mem_ce    (key_mem_ce),
    .key_mem_we    (key_mem_we),
    .key_mem_addr  (key_mem_addr),
    .key_mem_wdata (key_mem_wdata),
    .key_mem_rdata (key_mem_rdata)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping after the first error");
  endtask

  `include "host_tasks.svh"

  always #CLK_HALF_NS CLK = ~CLK;

  //////////////////////////////////////////////////
  // UART and accelerator models
  //////////////////////////////////////////////////

  initial begin
    forever begin
      @(negedge CLK);
      if (uart_tx_vld) begin
        tx_q.push_back(uart_tx_data);
        line_active = 1'b1;
        @(posedge CLK);
        #1;
        uart_busy = 1'b1;
        repeat (BUSY_CYCLES) @(posedge CLK);
        #1;
        uart_busy   = 1'b0;
        line_active = 1'b0;
      end
    end
  end

  always @(negedge CLK) begin
    if (ap_start) begin
      ap_start_cnt++;
    end
    if (uart_tx_vld && uart_busy) begin
      abort_run("A transmit strobe arrived while the UART was still busy");
    end
  end

  // ip[i] becomes ip[i] ^ key[i] at one element per two cycles
  task automatic accel_compute();
    byte_t a;
    byte_t k;
    @(posedge CLK);
    #1;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ip_mem_ce    = 1'b1;
      ip_mem_we    = 1'b0;
      ip_mem_addr  = addr_t'(i);
      key_mem_ce   = 1'b1;
      key_mem_we   = 1'b0;
      key_mem_addr = addr_t'(i);
      @(posedge CLK);
      #1;
      a = ip_mem_rdata;
      k = key_mem_rdata;
      compare_byte(a, ip_model[i], $sformatf("ip_mem_rdata at address %0d", i));
      compare_byte(k, key_model[i], $sformatf("key_mem_rdata at address %0d", i));
      ip_mem_we    = 1'b1;
      ip_mem_wdata = a ^ k;
      key_mem_ce   = 1'b0;
      @(posedge CLK);
      #1;
    end
    ip_mem_ce = 1'b0;
    ip_mem_we = 1'b0;
    repeat (ACCEL_LAT) @(posedge CLK);
    #1;
    ap_done = 1'b1;
    ap_done_cnt++;
    @(posedge CLK);
    #1;
    ap_done = 1'b0;
  endtask

  initial begin
    forever begin
      @(negedge CLK);
      if (ap_start) begin
        accel_compute();
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("The run hung: still going after %0d ns", WATCHDOG_NS));
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    CLK           = 1'b0;
    CPU_RESETN    = 1'b1;
    uart_rx_data  = '0;
    uart_rx_vld   = 1'b0;
    uart_busy     = 1'b0;
    ap_done       = 1'b0;
    ip_mem_ce     = 1'b0;
    ip_mem_we     = 1'b0;
    ip_mem_addr   = '0;
    ip_mem_wdata  = '0;
    key_mem_ce    = 1'b0;
    key_mem_we    = 1'b0;
    key_mem_addr  = '0;
    key_mem_wdata = '0;

    reset_stays_quiet();
    enter_input_bytes();
    enter_and_view_key();
    run_and_view_result();
    reject_non_commands();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
